/* hw/video_pkg.sv */
// display timing constants, sync polarities, horizontal line phase enum, rgb888 pixel type
`default_nettype none

package video_pkg;

	// --------------------
	// horizontal timing, clocks
	localparam int H_TOTAL  = 24; // full line period
	localparam int H_SYNC   = 2;  // hs pulse width
	localparam int H_BPORCH = 4;  // sync end to first active pixel
	localparam int H_RES    = 16; // active pixels per line

	// --------------------
	// vertical timing, lines
	localparam int V_TOTAL  = 8;  // full frame period
	localparam int V_SYNC   = 1;  // vs pulse width
	localparam int V_BPORCH = 2;  // sync end to first active line
	localparam int V_RES    = 4;  // active lines per frame

	// sync level while asserted, idle level is the inverse
	localparam logic HS_POL = 1'b1;
	localparam logic VS_POL = 1'b1;

	// read request to output pixel, fifo read stage included
	localparam int ALIGN_DEPTH = 2;

	// pixel and line counters share one width
	localparam int CNT_W = 5;

	// where the pixel counter sits inside a line
	typedef enum logic [1:0] {
		PH_SYNC,   // hs asserted
		PH_BPORCH, // back porch
		PH_ACTIVE, // pixels fetched here
		PH_FPORCH  // front porch up to wrap
	} line_phase_t;

	// full depth pixel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

endpackage

`default_nettype wire

/* hw/buffer_pkg.sv */
// packed rgb565 pixel type, fifo depth and pointer width
`default_nettype none

package buffer_pkg;

	// --------------------
	// stored pixel format
	typedef struct packed {
		logic [4:0] r; // top 5 bits of red
		logic [5:0] g; // top 6 bits of green
		logic [4:0] b; // top 5 bits of blue
	} rgb565_t;

	// --------------------
	// buffer geometry
	localparam int FIFO_DEPTH = 64; // one 16x4 frame
	localparam int FIFO_AW    = 6;  // log2 of depth, pointers wrap on their own

endpackage

`default_nettype wire

/* hw/input_packer.sv */
// write side of the pipe: frame start detect, arm gate, rgb888 to rgb565 truncation
`timescale 1ns/1ps
`default_nettype none

module input_packer (
	input  wire                 I_clk,
	input  wire                 rst_n1,
	input  wire                 de_in,    // source pixel valid
	input  wire                 vs_n_in,  // active low frame sync
	input  wire  [7:0]          r_in,
	input  wire  [7:0]          g_in,
	input  wire  [7:0]          b_in,
	output logic                wr_en,    // one clock behind de_in
	output buffer_pkg::rgb565_t wr_pixel
);

	logic               vs_n_d;      // last vs_n_in
	logic               armed;       // set on first frame start, held
	logic               frame_start; // vs_n falling edge
	video_pkg::rgb888_t pix_in;

	assign frame_start = vs_n_d & ~vs_n_in;
	assign pix_in      = '{r: r_in, g: g_in, b: b_in};

	// --------------------
	// control
	always_ff @(posedge I_clk or negedge rst_n1)
	begin
		if (!rst_n1)
		begin
			vs_n_d <= 1'b1; // idle high, no false edge out of reset
			armed  <= 1'b0;
			wr_en  <= 1'b0;
		end
		else
		begin
			vs_n_d <= vs_n_in;
			if (frame_start)
				armed <= 1'b1;
			// edge cycle already counts as armed
			wr_en <= de_in & (armed | frame_start);
		end
	end

	// drop the low bits, keep msbs
	always_ff @(posedge I_clk)
	begin
		wr_pixel <= '{r: pix_in.r[7:3], g: pix_in.g[7:2], b: pix_in.b[7:3]};
	end

	// nothing reaches the buffer ahead of the first frame
	a_wr_armed: assert property (@(posedge I_clk) disable iff (!rst_n1)
		wr_en |-> armed)
		else $error("write issued before frame start");

endmodule

`default_nettype wire

/* hw/pixel_fifo.sv */
// single clock circular buffer of rgb565 pixels with sticky overflow and underflow flags
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
	input  wire                 I_clk,
	input  wire                 rst_n1,
	input  wire                 wr_en,
	input  wire  buffer_pkg::rgb565_t wr_pixel,
	input  wire                 rd_en,     // display request, never stalls
	output buffer_pkg::rgb565_t rd_pixel,  // one clock after rd_en
	output logic                overflow,  // write while full seen
	output logic                underflow  // read while empty seen
);

	buffer_pkg::rgb565_t            mem [buffer_pkg::FIFO_DEPTH];
	logic [buffer_pkg::FIFO_AW-1:0] wr_ptr;
	logic [buffer_pkg::FIFO_AW-1:0] rd_ptr;
	logic [buffer_pkg::FIFO_AW:0]   count;  // one extra bit for full
	logic                           full;
	logic                           empty;
	logic                           wr_ok;
	logic                           rd_ok;

	assign full  = (int'(count) == buffer_pkg::FIFO_DEPTH);
	assign empty = (count == '0);
	assign wr_ok = wr_en & ~full;  // full drops the pixel
	assign rd_ok = rd_en & ~empty; // empty yields black

	// --------------------
	// pointers, occupancy, flags
	always_ff @(posedge I_clk or negedge rst_n1)
	begin
		if (!rst_n1)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
			if (wr_en & full)
				overflow <= 1'b1;
			if (rd_en & empty)
				underflow <= 1'b1;
		end
	end

	// storage and registered read port
	always_ff @(posedge I_clk)
	begin
		if (wr_ok)
			mem[wr_ptr] <= wr_pixel; // readable next clock
		rd_pixel <= rd_ok ? mem[rd_ptr] : '0; // black outside valid reads
	end

	// --------------------
	// occupancy checks
	a_count_max: assert property (@(posedge I_clk) disable iff (!rst_n1)
		int'(count) <= buffer_pkg::FIFO_DEPTH)
		else $error("fifo count above depth");

	a_count_hold: assert property (@(posedge I_clk) disable iff (!rst_n1)
		(wr_ok && rd_ok) |=> (count == $past(count)))
		else $error("fifo count moved on a read plus write");

endmodule

`default_nettype wire

/* hw/timing_gen.sv */
// display timing: pixel and line counters, line phase decode, read enable and sync outputs
`timescale 1ns/1ps
`default_nettype none

module timing_gen (
	input  wire  I_clk,
	input  wire  rst_n1,
	output logic rd_en,  // high exactly on active positions
	output logic hs_raw, // polarity applied
	output logic vs_raw
);

	logic [video_pkg::CNT_W-1:0] h_cnt;     // pixel within line
	logic [video_pkg::CNT_W-1:0] v_cnt;     // line within frame
	logic [video_pkg::CNT_W-1:0] h_nxt;
	logic [video_pkg::CNT_W-1:0] v_nxt;
	logic                        h_last;
	logic                        v_last;
	video_pkg::line_phase_t      phase;     // phase of the current count
	video_pkg::line_phase_t      phase_nxt;

	// int constant to counter width
	function automatic logic [video_pkg::CNT_W-1:0] cnt_of(input int n);
		return n[video_pkg::CNT_W-1:0];
	endfunction

	// horizontal position to phase
	function automatic video_pkg::line_phase_t phase_of(input logic [video_pkg::CNT_W-1:0] h);
		if (int'(h) < video_pkg::H_SYNC)
			return video_pkg::PH_SYNC;
		else if (int'(h) < video_pkg::H_SYNC + video_pkg::H_BPORCH)
			return video_pkg::PH_BPORCH;
		else if (int'(h) < video_pkg::H_SYNC + video_pkg::H_BPORCH + video_pkg::H_RES)
			return video_pkg::PH_ACTIVE;
		else
			return video_pkg::PH_FPORCH;
	endfunction

	// line inside the active window
	function automatic logic line_active(input logic [video_pkg::CNT_W-1:0] v);
		return (int'(v) >= video_pkg::V_SYNC + video_pkg::V_BPORCH) &&
			(int'(v) < video_pkg::V_SYNC + video_pkg::V_BPORCH + video_pkg::V_RES);
	endfunction

	// --------------------
	// next count
	assign h_last = (h_cnt == cnt_of(video_pkg::H_TOTAL - 1));
	assign v_last = (v_cnt == cnt_of(video_pkg::V_TOTAL - 1));

	always_comb
	begin
		h_nxt = h_last ? '0 : h_cnt + 1'b1;
		v_nxt = v_cnt;
		if (h_last)
			v_nxt = v_last ? '0 : v_cnt + 1'b1; // line advances on pixel wrap
	end

	assign phase     = phase_of(h_cnt);
	assign phase_nxt = phase_of(h_nxt);

	// outputs decoded from the next count, so they line up with h_cnt / v_cnt
	always_ff @(posedge I_clk or negedge rst_n1)
	begin
		if (!rst_n1)
		begin
			// parked on the last position, first clock lands on 0,0
			h_cnt  <= cnt_of(video_pkg::H_TOTAL - 1);
			v_cnt  <= cnt_of(video_pkg::V_TOTAL - 1);
			rd_en  <= 1'b0;
			hs_raw <= ~video_pkg::HS_POL;
			vs_raw <= ~video_pkg::VS_POL;
		end
		else
		begin
			h_cnt  <= h_nxt;
			v_cnt  <= v_nxt;
			rd_en  <= (phase_nxt == video_pkg::PH_ACTIVE) && line_active(v_nxt);
			hs_raw <= (phase_nxt == video_pkg::PH_SYNC) ? video_pkg::HS_POL : ~video_pkg::HS_POL;
			// whole lines of vs from line 0
			vs_raw <= (int'(v_nxt) < video_pkg::V_SYNC) ? video_pkg::VS_POL : ~video_pkg::VS_POL;
		end
	end

	// read request confined to the active phase
	a_rd_phase: assert property (@(posedge I_clk) disable iff (!rst_n1)
		rd_en |-> (phase == video_pkg::PH_ACTIVE))
		else $error("rd_en outside active phase");

endmodule

`default_nettype wire

/* hw/output_align.sv */
// output stage: enable and sync delay line, rgb565 to rgb888 expansion register
`timescale 1ns/1ps
`default_nettype none

module output_align (
	input  wire                 I_clk,
	input  wire                 rst_n1,
	input  wire                 rd_en,    // request, pixel follows a clock later
	input  wire                 hs_raw,
	input  wire                 vs_raw,
	input  wire  buffer_pkg::rgb565_t rd_pixel,
	output logic                de_out,
	output logic                hs_out,
	output logic                vs_out,
	output logic [7:0]          r_out,
	output logic [7:0]          g_out,
	output logic [7:0]          b_out
);

	logic [video_pkg::ALIGN_DEPTH-1:0] de_sr;
	logic [video_pkg::ALIGN_DEPTH-1:0] hs_sr;
	logic [video_pkg::ALIGN_DEPTH-1:0] vs_sr;
	video_pkg::rgb888_t                pix_q; // expanded pixel

	// --------------------
	// control delay line, oldest bit on top
	always_ff @(posedge I_clk or negedge rst_n1)
	begin
		if (!rst_n1)
		begin
			de_sr <= '0;
			hs_sr <= {video_pkg::ALIGN_DEPTH{~video_pkg::HS_POL}}; // idle levels
			vs_sr <= {video_pkg::ALIGN_DEPTH{~video_pkg::VS_POL}};
		end
		else
		begin
			de_sr <= {de_sr[video_pkg::ALIGN_DEPTH-2:0], rd_en};
			hs_sr <= {hs_sr[video_pkg::ALIGN_DEPTH-2:0], hs_raw};
			vs_sr <= {vs_sr[video_pkg::ALIGN_DEPTH-2:0], vs_raw};
		end
	end

	// fifo read is the first stage, this register the last
	always_ff @(posedge I_clk)
	begin
		pix_q <= '{r: {rd_pixel.r, 3'b000}, g: {rd_pixel.g, 2'b00}, b: {rd_pixel.b, 3'b000}};
	end

	assign de_out = de_sr[video_pkg::ALIGN_DEPTH-1];
	assign hs_out = hs_sr[video_pkg::ALIGN_DEPTH-1];
	assign vs_out = vs_sr[video_pkg::ALIGN_DEPTH-1];
	assign r_out  = pix_q.r;
	assign g_out  = pix_q.g;
	assign b_out  = pix_q.b;

endmodule

`default_nettype wire

/* hw/video_top.sv */
// video pipe top: packer, pixel fifo, timing generator and output alignment
`timescale 1ns/1ps
`default_nettype none

module video_top (
	input  wire        I_clk,
	input  wire        rst_n1,
	input  wire        de_in,
	input  wire        vs_n_in,   // frame start on falling edge
	input  wire  [7:0] r_in,
	input  wire  [7:0] g_in,
	input  wire  [7:0] b_in,
	output logic       de_out,
	output logic       hs_out,
	output logic       vs_out,
	output logic [7:0] r_out,
	output logic [7:0] g_out,
	output logic [7:0] b_out,
	output logic       overflow,  // sticky
	output logic       underflow  // sticky
);

	// --------------------
	// write side
	logic                wr_en;
	buffer_pkg::rgb565_t wr_pixel;

	// read side
	logic                rd_en;
	logic                hs_raw;
	logic                vs_raw;
	buffer_pkg::rgb565_t rd_pixel;

	input_packer input_packer_inst (
		.I_clk    (I_clk),
		.rst_n1   (rst_n1),
		.de_in    (de_in),
		.vs_n_in  (vs_n_in),
		.r_in     (r_in),
		.g_in     (g_in),
		.b_in     (b_in),
		.wr_en    (wr_en),
		.wr_pixel (wr_pixel)
	);

	pixel_fifo pixel_fifo_inst (
		.I_clk     (I_clk),
		.rst_n1    (rst_n1),
		.wr_en     (wr_en),
		.wr_pixel  (wr_pixel),
		.rd_en     (rd_en),     // paced by display timing only
		.rd_pixel  (rd_pixel),
		.overflow  (overflow),
		.underflow (underflow)
	);

	timing_gen timing_gen_inst (
		.I_clk  (I_clk),
		.rst_n1 (rst_n1),
		.rd_en  (rd_en),
		.hs_raw (hs_raw),
		.vs_raw (vs_raw)
	);

	output_align output_align_inst (
		.I_clk    (I_clk),
		.rst_n1   (rst_n1),
		.rd_en    (rd_en),
		.hs_raw   (hs_raw),
		.vs_raw   (vs_raw),
		.rd_pixel (rd_pixel),
		.de_out   (de_out),
		.hs_out   (hs_out),
		.vs_out   (vs_out),
		.r_out    (r_out),
		.g_out    (g_out),
		.b_out    (b_out)
	);

endmodule

`default_nettype wire

/* dv/video_model.svh */
// testbench reference model: expected pixel queue, arm state, rgb565 pack and expand
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// --------------------
// model state
logic [15:0] exp_q[$];   // packed pixels in write order
logic        model_armed; // first frame start seen

// keep the 5/6/5 msbs of each channel
function automatic logic [15:0] pack565(input logic [7:0] r, input logic [7:0] g,
	input logic [7:0] b);
	return {r[7:3], g[7:2], b[7:3]};
endfunction

// zeros into the low bits
function automatic logic [23:0] expand565(input logic [15:0] p);
	return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
endfunction

task automatic model_reset();
	exp_q.delete();
	model_armed = 1'b0;
endtask

// one source pixel, start marks a vs_n falling edge
task automatic model_write(input logic start, input logic [7:0] r, input logic [7:0] g,
	input logic [7:0] b);
	if (start)
		model_armed = 1'b1; // edge cycle itself is stored
	if (model_armed && exp_q.size() < buffer_pkg::FIFO_DEPTH)
		exp_q.push_back(pack565(r, g, b)); // full buffer drops it
endtask

// one displayed pixel
task automatic model_read(output logic [23:0] pix);
	if (exp_q.size() == 0)
		pix = '0; // empty buffer shows black
	else
		pix = expand565(exp_q.pop_front());
endtask

`endif

/* dv/tb_video_top.sv */
// video pipe testbench: clock, reset, watchdog, random pixels, output checks, summary
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

	localparam int FRAME_CLKS = video_pkg::H_TOTAL * video_pkg::V_TOTAL;

	logic        I_clk;
	logic        rst_n1;
	logic        de_in;
	logic        vs_n_in;
	logic [7:0]  r_in;
	logic [7:0]  g_in;
	logic [7:0]  b_in;
	logic        de_out;
	logic        hs_out;
	logic        vs_out;
	logic [7:0]  r_out;
	logic [7:0]  g_out;
	logic [7:0]  b_out;
	logic        overflow;
	logic        underflow;
	logic [23:0] exp_pix;
	int          err_cnt;
	int          de_cnt;  // output pixels seen
	int          n_pass;
	int          n_fail;
	int          t0;
	int          d0;
	int          gaps;

	`include "video_model.svh"

	video_top dut0 (
		.I_clk (I_clk), .rst_n1 (rst_n1), .de_in (de_in), .vs_n_in (vs_n_in),
		.r_in (r_in), .g_in (g_in), .b_in (b_in),
		.de_out (de_out), .hs_out (hs_out), .vs_out (vs_out),
		.r_out (r_out), .g_out (g_out), .b_out (b_out),
		.overflow (overflow), .underflow (underflow)
	);

	always #4 I_clk = ~I_clk; // 8 ns period

	// watchdog, 12 frames plus slack
	initial
	begin
		#(12 * FRAME_CLKS * 8 + 1000);
		$display("watchdog expired before the tests finished at %0t", $time);
		$display("Simulation FAILED");
		$finish;
	end

	// --------------------
	// output monitor, sampled mid cycle
	always @(negedge I_clk)
	begin
		if (rst_n1 && de_out)
		begin
			model_read(exp_pix);
			if ({r_out, g_out, b_out} !== exp_pix)
			begin
				$display("ERR t=%0t rgb_out got %06h exp %06h", $time, {r_out, g_out, b_out},
					exp_pix);
				err_cnt++;
			end
			de_cnt++;
		end
	end

	task automatic check_val(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_idle();
		check_val("de_out", de_out, 0);
		check_val("hs_out", hs_out, !video_pkg::HS_POL);
		check_val("vs_out", vs_out, !video_pkg::VS_POL);
		check_val("overflow", overflow, 0);
		check_val("underflow", underflow, 0);
	endtask

	// returns on the sample where vs_out turns active
	task automatic wait_vs_start();
		int  n;
		logic prev;
		logic seen;
		n = 0;
		prev = (vs_out == video_pkg::VS_POL);
		seen = 1'b0;
		while (!seen && n < 2 * FRAME_CLKS)
		begin
			@(negedge I_clk);
			n++;
			seen = (vs_out == video_pkg::VS_POL) && !prev;
			prev = (vs_out == video_pkg::VS_POL);
		end
		if (!seen)
		begin
			$display("vs_out never turned active within two frames at %0t", $time);
			err_cnt++;
		end
	endtask

	// one random pixel, start pulls vs_n low for this clock
	task automatic send_pixel(input logic start);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = 8'($urandom);
		g = 8'($urandom);
		b = 8'($urandom);
		@(posedge I_clk);
		de_in   <= 1'b1;
		vs_n_in <= ~start;
		r_in    <= r;
		g_in    <= g;
		b_in    <= b;
		model_write(start, r, g, b);
	endtask

	task automatic send_idle();
		@(posedge I_clk);
		de_in   <= 1'b0;
		vs_n_in <= 1'b1;
	endtask

	// called right at a vs_out activation, runs to the next one
	task automatic check_timing();
		int n;
		int vs_len;
		int hs_len;
		int hs_rise;
		int de_len;
		int de_runs;
		logic done;
		n = 1;
		vs_len = 1;
		hs_len = 1; // hs starts with vs
		hs_rise = 1;
		de_len = 0;
		de_runs = 0;
		done = 1'b0;
		while (!done && n < 2 * FRAME_CLKS)
		begin
			@(negedge I_clk);
			n++;
			if (vs_out == video_pkg::VS_POL && vs_len != n - 1)
				done = 1'b1; // next frame
			else
			begin
				if (vs_out == video_pkg::VS_POL)
					vs_len++;
				if (hs_out == video_pkg::HS_POL)
				begin
					if (hs_len == 0)
					begin
						check_val("hs_out period", n - hs_rise, video_pkg::H_TOTAL);
						hs_rise = n;
					end
					hs_len++;
				end
				else if (hs_len > 0)
				begin
					check_val("hs_out width", hs_len, video_pkg::H_SYNC);
					hs_len = 0;
				end
				if (de_out)
					de_len++;
				else if (de_len > 0)
				begin
					check_val("de_out run", de_len, video_pkg::H_RES);
					de_runs++;
					de_len = 0;
				end
			end
		end
		check_val("frame clocks", n - 1, FRAME_CLKS);
		check_val("vs_out width", vs_len, video_pkg::V_SYNC * video_pkg::H_TOTAL);
		check_val("de_out lines", de_runs, video_pkg::V_RES);
	endtask

	task automatic finish_test(input string name, input int e0);
		if (err_cnt == e0)
		begin
			n_pass++;
			$display("test %s: ok", name);
		end
		else
		begin
			n_fail++;
			$display("test %s: %0d errors", name, err_cnt - e0);
		end
	endtask

	// --------------------
	// test sequence
	initial
	begin
		void'($urandom(32'h63bb_a82a));
		I_clk = 1'b0;
		rst_n1 = 1'b0;
		de_in = 1'b0;
		vs_n_in = 1'b1; // sync idle
		r_in = '0;
		g_in = '0;
		b_in = '0;
		err_cnt = 0;
		de_cnt = 0;
		n_pass = 0;
		n_fail = 0;
		model_reset();

		t0 = err_cnt;
		repeat (5)
		begin
			@(negedge I_clk);
			check_idle();
		end
		@(posedge I_clk);
		rst_n1 <= 1'b1;
		@(negedge I_clk);
		check_idle();
		finish_test("reset", t0);

		// pixels ahead of any frame start, frame 0 must show black
		t0 = err_cnt;
		d0 = de_cnt;
		repeat (20)
			send_pixel(1'b0);
		send_idle();
		wait_vs_start();
		check_val("pixels shown", de_cnt - d0, video_pkg::H_RES * video_pkg::V_RES);
		finish_test("frame gate", t0);

		t0 = err_cnt;
		check_timing();
		finish_test("timing", t0);

		// one frame in vertical blanking, up to 8 single gaps
		t0 = err_cnt;
		d0 = de_cnt;
		gaps = 0;
		send_pixel(1'b1);
		for (int i = 1; i < buffer_pkg::FIFO_DEPTH; i++)
		begin
			if (gaps < 8 && ($urandom % 8) == 0)
			begin
				send_idle();
				gaps++;
			end
			send_pixel(1'b0);
		end
		send_idle();
		wait_vs_start();
		check_val("pixels shown", de_cnt - d0, buffer_pkg::FIFO_DEPTH);
		check_val("queue left", exp_q.size(), 0);
		finish_test("data path", t0);

		// starved frame, every shown pixel black
		t0 = err_cnt;
		d0 = de_cnt;
		check_val("queue left", exp_q.size(), 0);
		wait_vs_start();
		check_val("pixels shown", de_cnt - d0, video_pkg::H_RES * video_pkg::V_RES);
		check_val("underflow", underflow, 1);
		check_val("overflow", overflow, 0);
		finish_test("underflow", t0);

		// eight more than the buffer holds, back to back
		t0 = err_cnt;
		send_pixel(1'b1);
		for (int i = 1; i < buffer_pkg::FIFO_DEPTH + 8; i++)
			send_pixel(1'b0);
		send_idle();
		wait_vs_start();
		check_val("overflow", overflow, 1);
		check_val("queue left", exp_q.size(), 0);
		finish_test("overflow", t0);

		$display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, err_cnt);
		if (n_fail == 0 && err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* video_pipe.f */
+incdir+dv
hw/video_pkg.sv
hw/buffer_pkg.sv
hw/input_packer.sv
hw/pixel_fifo.sv
hw/timing_gen.sv
hw/output_align.sv
hw/video_top.sv
dv/tb_video_top.sv

/* run_sim.sh */
#!/bin/bash
# build the video pipe testbench with Verilator, run it, scan the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_top \
	-f video_pipe.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi
echo "run clean"
